// ==== flist.f ====
+incdir+verification
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/apbCtrlPort.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/cpuTop.sv
verification/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module cpuTb \
  -f flist.f -o cpuSim || exit 1
out=$(./obj_dir/cpuSim)
echo "$out"
echo "$out" | grep -q "All tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/cpuTbTasks.svh ====
`ifndef CPU_TB_TASKS_SVH
`define CPU_TB_TASKS_SVH

// ------------------------------
// instruction encoders
// ------------------------------
function automatic wordT rIns(logic [5:0] funct, int rd, int rs, int rt);
  return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
endfunction

// text order, op rt, rs, imm
function automatic wordT iIns(opcodeT op, int rt, int rs, int imm);
  return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

// offset counts words past pc+4
function automatic wordT brIns(opcodeT op, int rs, int rt, int at, int target);
  return {op, 5'(rs), 5'(rt), 16'(target - at - 1)};
endfunction

function automatic wordT jIns(int target);
  return {j, 26'(target)};  // programs live below 256 MB
endfunction

function automatic wordT haltIns();
  return {halt, 26'd0};
endfunction

function automatic wordT sext16(wordT v);
  return {{16{v[15]}}, v[15:0]};
endfunction

// known background, unique per byte address
function automatic wordT fillWord(int k);
  return {20'hfacef, dmemBase + 12'(4 * k)};
endfunction

// ------------------------------
// apb driver
// ------------------------------
task automatic apbWrite(input logic [11:0] addr, input wordT data, output logic err);
  @(posedge clk);
  #1;
  apbReq = '{sel: 1'b1, enable: 1'b0, write: 1'b1, addr: addr, wdata: data};  // setup
  @(posedge clk);
  #1;
  apbReq.enable = 1'b1;
  @(negedge clk);       // access phase, response settled
  err = apbRsp.slvErr;
  checkEq("apbRsp.ready", {31'd0, apbRsp.ready}, 32'd1);
  @(posedge clk);
  #1;
  apbReq = '0;
endtask

task automatic apbRead(input logic [11:0] addr, output wordT data, output logic err);
  @(posedge clk);
  #1;
  apbReq = '{sel: 1'b1, enable: 1'b0, write: 1'b0, addr: addr, wdata: '0};
  @(posedge clk);
  #1;
  apbReq.enable = 1'b1;
  @(negedge clk);
  data = apbRsp.rdata;
  err  = apbRsp.slvErr;
  checkEq("apbRsp.ready", {31'd0, apbRsp.ready}, 32'd1);
  @(posedge clk);
  #1;
  apbReq = '0;
endtask

task automatic writeOk(input logic [11:0] addr, input wordT data);
  logic err;
  apbWrite(addr, data, err);
  checkEq($sformatf("slvErr wr %h", addr), {31'd0, err}, 32'd0);
endtask

task automatic readOk(input logic [11:0] addr, output wordT data);
  logic err;
  apbRead(addr, data, err);
  checkEq($sformatf("slvErr rd %h", addr), {31'd0, err}, 32'd0);
endtask

// ------------------------------
// program and memory helpers
// ------------------------------
task automatic loadProgram();
  foreach (prog[i])
    writeOk(imemBase + 12'(4 * i), prog[i]);
endtask

task automatic preload(input int k, input wordT v);
  writeOk(dmemBase + 12'(4 * k), v);
  expMem[k] = v;
endtask

task automatic fillDmem();
  for (int k = 0; k < dmemWords; k++)
    preload(k, fillWord(k));
endtask

task automatic startCore();
  writeOk(ctrlAddr, 32'd1);  // running from the end of this transfer
endtask

task automatic waitHalted(input int limit);
  int n;
  n = 0;
  while (!halted) begin
    @(posedge clk);
    #1;
    n++;
    if (n > limit) begin
      $display("core did not halt within %0d cycles", limit);
      abortRun();
    end
  end
endtask

task automatic checkDmem();
  wordT got;
  for (int k = 0; k < dmemWords; k++) begin
    readOk(dmemBase + 12'(4 * k), got);
    checkEq($sformatf("dmem[%0d]", k), got, expMem[k]);
  end
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic apbAccessTest();
  wordT rd;
  logic err;
  for (int k = 0; k < dmemWords; k++)
    preload(k, randBits(32));
  checkDmem();
  apbRead(12'hc00, rd, err);          // no window there
  checkEq("slvErr unmapped rd", {31'd0, err}, 32'd1);
  apbWrite(12'h808, 32'h1, err);
  checkEq("slvErr unmapped wr", {31'd0, err}, 32'd1);
  apbRead(12'h100, rd, err);          // imem word 64, past the depth
  checkEq("slvErr imem depth", {31'd0, err}, 32'd1);

  // countdown loop, keeps the core busy
  prog.delete();
  prog.push_back(iIns(addi, 1, 0, 40));
  prog.push_back(iIns(addi, 1, 1, -1));
  prog.push_back(brIns(bne, 1, 0, 2, 1));
  prog.push_back(haltIns());
  loadProgram();
  startCore();
  readOk(ctrlAddr, rd);
  checkEq("status running", rd, 32'd1);
  apbWrite(dmemBase, ~expMem[0], err);
  checkEq("slvErr dmem wr busy", {31'd0, err}, 32'd1);
  apbRead(dmemBase + 12'h4, rd, err);
  checkEq("slvErr dmem rd busy", {31'd0, err}, 32'd1);
  apbWrite(imemBase + 12'hc, rIns(functAdd, 0, 0, 0), err);  // would remove the halt
  checkEq("slvErr imem wr busy", {31'd0, err}, 32'd1);
  waitHalted(400);
  readOk(ctrlAddr, rd);
  checkEq("status halted", rd, 32'd2);
  checkDmem();                        // blocked write left no trace
  $display("apb access test done");
endtask

task automatic forwardTest();
  wordT rf[32];
  wordT im1;
  wordT im2;
  int   storeRegs[8];
  storeRegs = '{4, 5, 6, 7, 8, 9, 11, 12};
  rf[1] = randBits(32);
  rf[2] = randBits(32);
  rf[3] = randBits(32);
  im1   = randBits(16);
  im2   = randBits(16);
  fillDmem();
  preload(0, rf[1]);
  preload(1, rf[2]);
  preload(2, rf[3]);

  // expected register values, 32-bit wraparound
  rf[4]  = rf[1] + rf[2];
  rf[5]  = rf[4] - rf[3];
  rf[6]  = rf[5] & rf[1];
  rf[7]  = rf[6] | rf[4];
  rf[8]  = ($signed(rf[7]) < $signed(rf[2])) ? 32'd1 : 32'd0;
  rf[9]  = rf[8] + sext16(im1);
  rf[11] = ($signed(rf[2]) < $signed(rf[7])) ? 32'd1 : 32'd0;
  rf[12] = rf[5] + sext16(im2);
  rf[13] = rf[12] + rf[9];
  foreach (storeRegs[k])
    expMem[4 + k] = rf[storeRegs[k]];
  expMem[12] = rf[13];

  prog.delete();
  prog.push_back(iIns(lw, 1, 0, 0));
  prog.push_back(iIns(lw, 2, 0, 4));
  prog.push_back(iIns(lw, 3, 0, 8));
  prog.push_back(rIns(functAdd, 4, 1, 2));
  prog.push_back(rIns(functSub, 5, 4, 3));    // ex/mem and wb sources
  prog.push_back(rIns(functAnd, 6, 5, 1));
  prog.push_back(rIns(functOr, 7, 6, 4));
  prog.push_back(rIns(functSlt, 8, 7, 2));
  prog.push_back(iIns(addi, 9, 8, int'(im1)));
  prog.push_back(rIns(functSlt, 11, 2, 7));
  prog.push_back(iIns(addi, 12, 5, int'(im2)));
  prog.push_back(rIns(functAdd, 13, 12, 9));
  prog.push_back(iIns(sw, 13, 0, 48));        // store data forwarded
  foreach (storeRegs[k])
    prog.push_back(iIns(sw, storeRegs[k], 0, 16 + 4 * k));
  prog.push_back(haltIns());
  loadProgram();
  startCore();
  waitHalted(100);
  checkDmem();
  $display("forwarding test done");
endtask

task automatic loadUseTest();
  wordT p;
  wordT q;
  wordT s;
  p = randBits(32);
  q = randBits(32);
  s = randBits(32);
  fillDmem();
  preload(0, p);
  preload(1, q);
  preload(2, p);
  preload(3, s);
  expMem[4] = p + p;
  expMem[6] = q;
  expMem[7] = (p + p) - s;   // word 5 sits on the skipped path

  prog.delete();
  prog.push_back(iIns(lw, 1, 0, 0));
  prog.push_back(rIns(functAdd, 2, 1, 1));     // load-use
  prog.push_back(iIns(sw, 2, 0, 16));
  prog.push_back(iIns(lw, 4, 0, 8));
  prog.push_back(brIns(beq, 4, 1, 4, 6));      // taken on loaded value
  prog.push_back(iIns(sw, 2, 0, 20));
  prog.push_back(iIns(lw, 3, 0, 4));
  prog.push_back(brIns(bne, 3, 3, 7, 9));      // never taken
  prog.push_back(iIns(sw, 3, 0, 24));
  prog.push_back(iIns(lw, 5, 0, 12));
  prog.push_back(rIns(functSub, 6, 2, 5));     // load-use on rt
  prog.push_back(iIns(sw, 6, 0, 28));
  prog.push_back(haltIns());
  loadProgram();
  startCore();
  waitHalted(100);
  checkDmem();
  $display("load-use test done");
endtask

task automatic controlFlowTest();
  int n;
  n = 5 + int'(randBits(3));
  fillDmem();
  expMem[0] = 32'(n);         // loop count
  expMem[1] = 32'(3 * n);
  expMem[3] = 32'(n);
  expMem[6] = 32'(3 * n);

  prog.delete();
  prog.push_back(iIns(addi, 1, 0, n));
  prog.push_back(iIns(addi, 2, 0, 0));
  prog.push_back(iIns(addi, 3, 0, 0));
  prog.push_back(iIns(addi, 2, 2, 1));         // loop body at 3
  prog.push_back(iIns(addi, 3, 3, 3));
  prog.push_back(brIns(bne, 2, 1, 5, 3));
  prog.push_back(iIns(sw, 2, 0, 0));
  prog.push_back(iIns(sw, 3, 0, 4));
  prog.push_back(brIns(beq, 2, 1, 8, 10));     // taken
  prog.push_back(iIns(sw, 2, 0, 8));           // squashed
  prog.push_back(brIns(beq, 2, 0, 10, 12));    // not taken
  prog.push_back(iIns(sw, 1, 0, 12));
  prog.push_back(jIns(15));
  prog.push_back(iIns(sw, 1, 0, 16));          // jumped over
  prog.push_back(iIns(sw, 1, 0, 20));
  prog.push_back(iIns(sw, 3, 0, 24));
  prog.push_back(haltIns());
  loadProgram();
  startCore();
  waitHalted(150);
  checkDmem();
  $display("control flow test done, %0d loop passes", n);
endtask

task automatic haltCountTest();
  wordT k1;
  wordT k2;
  wordT rd;
  int   progLen;
  k1 = randBits(15);
  k2 = randBits(15);
  fillDmem();
  expMem[0] = k1 + k2;
  expMem[1] = k1;

  // no stalls, no branches
  prog.delete();
  prog.push_back(iIns(addi, 1, 0, int'(k1)));
  prog.push_back(iIns(addi, 2, 0, int'(k2)));
  prog.push_back(rIns(functAdd, 3, 1, 2));
  prog.push_back(iIns(sw, 3, 0, 0));
  prog.push_back(iIns(sw, 1, 0, 4));
  prog.push_back(haltIns());
  progLen = prog.size();
  prog.push_back(iIns(sw, 1, 0, 8));           // behind the halt
  prog.push_back(iIns(sw, 2, 0, 12));
  loadProgram();
  startCore();
  checkEq("halted after start", {31'd0, halted}, 32'd0);  // set by the previous run
  waitHalted(100);
  readOk(ctrlAddr, rd);
  checkEq("status", rd, 32'd2);
  readOk(cycleAddr, rd);
  checkEq("cycle count", rd, 32'(progLen + 4));
  checkDmem();
  $display("halt and cycle count test done");
endtask

`endif

// ==== verification/cpuTb.sv ====
`default_nettype none

module cpuTb;
  timeunit 1ns;
  timeprecision 1ps;

  import cpuPkg::*;

  localparam int imemDepth     = 64;
  localparam int dmemDepth     = 64;
  localparam int dmemWords     = 32;    // words filled and read back per test
  localparam int timeoutCycles = 4000;  // about twice the summed test lengths

  logic   clk;
  logic   rstN;
  apbReqT apbReq;
  apbRspT apbRsp;
  logic   halted;

  wordT lfsr;
  int   errCount;
  int   cycles;
  wordT prog[$];            // image for the next program load
  wordT expMem[dmemWords];  // expected data memory contents

  cpuTop #(
    .imemDepth (imemDepth),
    .dmemDepth (dmemDepth)
  ) u_dut (
    .clk    (clk),
    .rstN   (rstN),
    .apbReq (apbReq),
    .apbRsp (apbRsp),
    .halted (halted)
  );

  always #4 clk = ~clk;  // 8 ns period

  // ------------------------------
  // timeout, random data
  // ------------------------------
  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeoutCycles) begin
      $display("run timed out after %0d cycles", cycles);
      abortRun();
    end
  end

  // galois form, taps 32 22 2 1
  function automatic logic lfsrBit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic wordT randBits(int n);
    wordT v;
    v = '0;
    for (int k = 0; k < n; k++)
      v = {v[30:0], lfsrBit()};  // one step per bit
    return v;
  endfunction

  // ------------------------------
  // checking
  // ------------------------------
  task automatic abortRun();
    $display("Some tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkEq(input string what, input wordT got, input wordT exp);
    if (got !== exp) begin
      errCount++;
      $display("FAILED at %0t ns: %s = %h, expected %h", $time, what, got, exp);
      abortRun();
    end
  endtask

  `include "cpuTbTasks.svh"

  initial begin
    clk      = 1'b0;
    rstN     = 1'b0;
    apbReq   = '0;
    lfsr     = 32'h1d3e;
    errCount = 0;
    cycles   = 0;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;

    apbAccessTest();
    forwardTest();
    loadUseTest();
    controlFlowTest();
    haltCountTest();

    if (errCount == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      abortRun();
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cpuTop.sv ====
`default_nettype none

module cpuTop #(
  parameter int imemDepth = 64,
  parameter int dmemDepth = 64
) (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::apbReqT apbReq,
  output cpuPkg::apbRspT apbRsp,
  output logic           halted
);
  import cpuPkg::*;

  logic   running;
  logic   stall;
  logic   redirect;
  wordT   redirectPc;
  logic   imemWe;
  logic   dmemSel;
  logic   dmemWe;
  memIdxT memIdx;
  wordT   memWdata;
  wordT   dmemRdata;
  ifIdT   ifId;
  idExT   idEx;
  exMemT  exMem;
  wbT     wb;       // writeback bus, also the halt report

  // ------------------------------
  // host side
  // ------------------------------
  apbCtrlPort #(
    .imemDepth (imemDepth),
    .dmemDepth (dmemDepth)
  ) uApb (
    .clk       (clk),
    .rstN      (rstN),
    .apbReq    (apbReq),
    .apbRsp    (apbRsp),
    .wb        (wb),
    .dmemRdata (dmemRdata),
    .running   (running),
    .halted    (halted),
    .imemWe    (imemWe),
    .dmemSel   (dmemSel),
    .dmemWe    (dmemWe),
    .memIdx    (memIdx),
    .memWdata  (memWdata)
  );

  // ------------------------------
  // pipeline
  // ------------------------------
  fetchStage #(.imemDepth(imemDepth)) uFetch (
    .clk        (clk),
    .rstN       (rstN),
    .running    (running),
    .stall      (stall),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .imemWe     (imemWe),
    .memIdx     (memIdx),
    .memWdata   (memWdata),
    .ifId       (ifId)
  );

  decodeStage uDecode (
    .clk        (clk),
    .rstN       (rstN),
    .running    (running),
    .ifId       (ifId),
    .exFwd      (exMem),
    .wb         (wb),
    .stall      (stall),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .idEx       (idEx)
  );

  executeStage uExecute (
    .clk     (clk),
    .rstN    (rstN),
    .running (running),
    .idEx    (idEx),
    .exMem   (exMem),
    .wb      (wb)
  );

  memoryStage #(.dmemDepth(dmemDepth)) uMemory (
    .clk       (clk),
    .rstN      (rstN),
    .running   (running),
    .exMem     (exMem),
    .dmemSel   (dmemSel),
    .dmemWe    (dmemWe),
    .memIdx    (memIdx),
    .memWdata  (memWdata),
    .dmemRdata (dmemRdata),
    .wb        (wb)
  );

endmodule

`default_nettype wire

// ==== hdl/memoryStage.sv ====
`default_nettype none

module memoryStage #(
  parameter int dmemDepth = 64
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic           running,
  input  cpuPkg::exMemT  exMem,
  input  logic           dmemSel,
  input  logic           dmemWe,
  input  cpuPkg::memIdxT memIdx,
  input  cpuPkg::wordT   memWdata,
  output cpuPkg::wordT   dmemRdata,
  output cpuPkg::wbT     wb
);
  import cpuPkg::*;

  localparam int idxW = $clog2(dmemDepth);

  wordT            dmem [dmemDepth];
  logic [idxW-1:0] pipeIdx;
  logic [idxW-1:0] apbIdx;
  wordT            loadData;
  logic            pipeWe;
  logic            apbWe;

  assign pipeIdx   = exMem.result[idxW+1:2];  // byte address to word
  assign apbIdx    = memIdx[idxW-1:0];
  assign loadData  = dmem[pipeIdx];
  assign dmemRdata = dmem[apbIdx];            // same-cycle apb read

  // core owns the memory while running, apb while stopped
  assign pipeWe = running && exMem.valid && exMem.memWrite;
  assign apbWe  = !running && dmemSel && dmemWe;

  always_ff @(posedge clk) begin
    if (pipeWe)
      dmem[pipeIdx] <= exMem.storeData;
    else if (apbWe)
      dmem[apbIdx] <= memWdata;
  end

  // ------------------------------
  // mem/wb register
  // ------------------------------
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wb <= '0;
    end else if (!running) begin
      wb <= '0;
    end else begin
      wb.regWrite <= exMem.valid && exMem.regWrite;
      wb.rd       <= exMem.rd;
      wb.data     <= exMem.memRead ? loadData : exMem.result;
      wb.halt     <= exMem.valid && exMem.halt;  // seen by apbCtrlPort
    end
  end

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
`default_nettype none

module executeStage (
  input  logic          clk,
  input  logic          rstN,
  input  logic          running,
  input  cpuPkg::idExT  idEx,
  output cpuPkg::exMemT exMem,
  input  cpuPkg::wbT    wb
);
  import cpuPkg::*;

  fwdSelT fwdA;
  fwdSelT fwdB;
  wordT   opA;
  wordT   opRt;     // forwarded rt, also store data
  wordT   opB;
  wordT   result;
  exMemT  nxt;

  // youngest producer first
  function automatic fwdSelT pickFwd(regIdxT r, exMemT em, wbT w);
    if (r == '0)
      return fwdNone;
    if (em.valid && em.regWrite && em.rd == r)
      return fwdMem;
    if (w.regWrite && w.rd == r)
      return fwdWb;
    return fwdNone;
  endfunction

  function automatic wordT fwdMux(fwdSelT sel, wordT regVal, exMemT em, wbT w);
    case (sel)
      fwdMem:  return em.result;
      fwdWb:   return w.data;
      default: return regVal;
    endcase
  endfunction

  assign fwdA = pickFwd(idEx.rs, exMem, wb);
  assign fwdB = pickFwd(idEx.rt, exMem, wb);
  assign opA  = fwdMux(fwdA, idEx.rsVal, exMem, wb);
  assign opRt = fwdMux(fwdB, idEx.rtVal, exMem, wb);
  assign opB  = idEx.aluSrc ? idEx.imm : opRt;

  // ------------------------------
  // alu
  // ------------------------------
  always_comb begin
    case (idEx.aluOp)
      aluAdd:  result = opA + opB;    // also lw/sw address
      aluSub:  result = opA - opB;
      aluAnd:  result = opA & opB;
      aluOr:   result = opA | opB;
      aluSlt:  result = {31'd0, $signed(opA) < $signed(opB)};
      default: result = '0;
    endcase
  end

  always_comb begin
    nxt           = '0;
    nxt.valid     = idEx.valid;
    nxt.result    = result;
    nxt.storeData = opRt;
    nxt.rd        = idEx.rd;
    nxt.memRead   = idEx.memRead;
    nxt.memWrite  = idEx.memWrite;
    nxt.regWrite  = idEx.regWrite;
    nxt.halt      = idEx.halt;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      exMem <= '0;
    else if (!running)
      exMem <= '0;
    else
      exMem <= nxt;
  end

  // r0 results written anywhere in the pipe must never reach an operand
  aNoFwdFromZero: assert property (@(posedge clk) disable iff (!rstN)
    idEx.valid |-> (idEx.rs != '0 || opA == '0) &&
                   (idEx.rt != '0 || opRt == '0));

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`default_nettype none

module decodeStage (
  input  logic          clk,
  input  logic          rstN,
  input  logic          running,
  input  cpuPkg::ifIdT  ifId,
  input  cpuPkg::exMemT exFwd,
  input  cpuPkg::wbT    wb,
  output logic          stall,
  output logic          redirect,
  output cpuPkg::wordT  redirectPc,
  output cpuPkg::idExT  idEx
);
  import cpuPkg::*;

  opcodeT op;
  regIdxT rs;
  regIdxT rt;
  regIdxT rd;
  wordT   imm;
  wordT   rsData;
  wordT   rtData;
  wordT   rsBr;       // branch compare operands
  wordT   rtBr;
  logic   haltSeen;   // halt issued, only bubbles follow
  logic   decValid;
  logic   usesRs;
  logic   usesRt;
  logic   isBranch;
  logic   isJump;
  logic   taken;
  logic   loadUse;
  logic   brHazEx;
  logic   brHazMem;
  logic   hazStall;
  idExT   nxt;

  // only the ex/mem result is needed here, writeback is bypassed in regFile
  function automatic wordT brFwd(regIdxT r, wordT regVal, exMemT e);
    if (e.valid && e.regWrite && e.rd != '0 && e.rd == r)
      return e.result;
    return regVal;
  endfunction

  assign op  = opcodeT'(ifId.instr[31:26]);
  assign rs  = ifId.instr[25:21];
  assign rt  = ifId.instr[20:16];
  assign rd  = ifId.instr[15:11];
  assign imm = {{16{ifId.instr[15]}}, ifId.instr[15:0]};

  regFile uRegFile (
    .clk    (clk),
    .rstN   (rstN),
    .rs     (rs),
    .rt     (rt),
    .wb     (wb),
    .rsData (rsData),
    .rtData (rtData)
  );

  assign decValid = ifId.valid && !haltSeen;
  assign isBranch = (op == beq) || (op == bne);
  assign isJump   = op == j;
  assign usesRs   = !isJump && (op != halt);
  assign usesRt   = (op == rType) || (op == sw) || isBranch;

  // ------------------------------
  // hazards
  // ------------------------------
  assign loadUse = idEx.valid && idEx.memRead && idEx.rd != '0 &&
                   ((usesRs && idEx.rd == rs) || (usesRt && idEx.rd == rt));
  // branch operand still being computed in ex
  assign brHazEx = isBranch && idEx.valid && idEx.regWrite && idEx.rd != '0 &&
                   (idEx.rd == rs || idEx.rd == rt);
  // load in mem, its data is only ready in wb
  assign brHazMem = isBranch && exFwd.valid && exFwd.memRead && exFwd.rd != '0 &&
                    (exFwd.rd == rs || exFwd.rd == rt);
  assign hazStall = decValid && (loadUse || brHazEx || brHazMem);

  // halt holds pc and if/id so nothing behind it gets decoded
  assign stall = hazStall || (ifId.valid && op == halt);

  // ------------------------------
  // branch and jump resolution
  // ------------------------------
  assign rsBr  = brFwd(rs, rsData, exFwd);
  assign rtBr  = brFwd(rt, rtData, exFwd);
  assign taken = isBranch && ((op == beq) == (rsBr == rtBr));

  assign redirect   = decValid && !hazStall && (taken || isJump);
  assign redirectPc = isJump ? {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00}
                             : ifId.pcPlus4 + {imm[29:0], 2'b00};

  // control decode
  always_comb begin
    nxt       = '0;
    nxt.valid = decValid && !hazStall;
    nxt.rsVal = rsData;
    nxt.rtVal = rtData;
    nxt.imm   = imm;
    nxt.rs    = rs;
    nxt.rt    = rt;
    nxt.rd    = rt;                     // i-type target
    nxt.aluOp = aluAdd;
    case (op)
      rType: begin
        nxt.rd       = rd;
        nxt.regWrite = 1'b1;
        case (ifId.instr[5:0])
          functAdd: nxt.aluOp = aluAdd;
          functSub: nxt.aluOp = aluSub;
          functAnd: nxt.aluOp = aluAnd;
          functOr:  nxt.aluOp = aluOr;
          functSlt: nxt.aluOp = aluSlt;
          default:  nxt.regWrite = 1'b0;  // unknown funct runs as a nop
        endcase
      end
      addi: begin
        nxt.aluSrc   = 1'b1;
        nxt.regWrite = 1'b1;
      end
      lw: begin
        nxt.aluSrc   = 1'b1;
        nxt.memRead  = 1'b1;
        nxt.regWrite = 1'b1;
      end
      sw: begin
        nxt.aluSrc   = 1'b1;
        nxt.memWrite = 1'b1;
      end
      halt:    nxt.halt = 1'b1;
      default: nxt.rd = '0;             // beq, bne, j finish here
    endcase
    if (!nxt.valid)
      nxt = '0;                         // bubble
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idEx     <= '0;
      haltSeen <= 1'b0;
    end else if (!running) begin
      idEx     <= '0;
      haltSeen <= 1'b0;
    end else begin
      idEx <= nxt;
      if (nxt.valid && nxt.halt)
        haltSeen <= 1'b1;
    end
  end

  // fetch would drop the redirect if both arrived together
  aNoRedirectOnStall: assert property (@(posedge clk) disable iff (!rstN)
    !(redirect && stall));

endmodule

`default_nettype wire

// ==== hdl/fetchStage.sv ====
`default_nettype none

module fetchStage #(
  parameter int imemDepth = 64
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic           running,
  input  logic           stall,
  input  logic           redirect,
  input  cpuPkg::wordT   redirectPc,
  input  logic           imemWe,
  input  cpuPkg::memIdxT memIdx,
  input  cpuPkg::wordT   memWdata,
  output cpuPkg::ifIdT   ifId
);
  import cpuPkg::*;

  localparam int idxW = $clog2(imemDepth);

  wordT imem [imemDepth];
  wordT pc;
  wordT pcPlus4;
  wordT fetchWord;

  assign pcPlus4   = pc + 32'd4;
  assign fetchWord = imem[pc[idxW+1:2]];  // async read on word address

  // program load over apb, core stopped
  always_ff @(posedge clk) begin
    if (imemWe)
      imem[memIdx[idxW-1:0]] <= memWdata;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc   <= '0;
      ifId <= '0;
    end else if (!running) begin
      pc   <= '0;                       // next run starts at address 0
      ifId <= '0;
    end else if (redirect) begin
      pc         <= redirectPc;
      ifId.valid <= 1'b0;               // squash the wrong-path slot
    end else if (!stall) begin
      pc           <= pcPlus4;
      ifId.valid   <= 1'b1;
      ifId.instr   <= fetchWord;
      ifId.pcPlus4 <= pcPlus4;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/apbCtrlPort.sv ====
`default_nettype none

module apbCtrlPort #(
  parameter int imemDepth = 64,
  parameter int dmemDepth = 64
) (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::apbReqT apbReq,
  output cpuPkg::apbRspT apbRsp,
  input  cpuPkg::wbT     wb,
  input  cpuPkg::wordT   dmemRdata,
  output logic           running,
  output logic           halted,
  output logic           imemWe,
  output logic           dmemSel,
  output logic           dmemWe,
  output cpuPkg::memIdxT memIdx,
  output cpuPkg::wordT   memWdata
);
  import cpuPkg::*;

  logic access;   // access phase of a transfer
  logic inImem;
  logic inDmem;
  logic isCtrl;
  logic isCycle;
  logic memHit;
  logic slvErr;
  logic start;
  wordT cycleCnt;
  wordT rdata;

  assign access   = apbReq.sel && apbReq.enable;
  assign memIdx   = apbReq.addr[9:2];  // word offset in window
  assign memWdata = apbReq.wdata;

  // ------------------------------
  // address decode
  // ------------------------------
  // only the first depth words of each window are backed by memory
  assign inImem  = (apbReq.addr[11:10] == imemBase[11:10]) && (int'(memIdx) < imemDepth);
  assign inDmem  = (apbReq.addr[11:10] == dmemBase[11:10]) && (int'(memIdx) < dmemDepth);
  assign isCtrl  = apbReq.addr == ctrlAddr;
  assign isCycle = apbReq.addr == cycleAddr;
  assign memHit  = inImem || inDmem;

  // memories belong to the core while it runs
  assign imemWe  = access && apbReq.write && inImem && !running;
  assign dmemSel = access && inDmem && !running;
  assign dmemWe  = dmemSel && apbReq.write;
  assign start   = access && apbReq.write && isCtrl && apbReq.wdata[0] && !running;

  assign slvErr = access && (!(memHit || isCtrl || isCycle) || (memHit && running));

  always_comb begin
    rdata = '0;
    if (dmemSel)
      rdata = dmemRdata;               // combinational dmem read
    else if (isCtrl)
      rdata = {30'd0, halted, running};
    else if (isCycle)
      rdata = cycleCnt;
  end

  assign apbRsp = '{rdata: rdata, ready: 1'b1, slvErr: slvErr};  // zero wait states

  // ------------------------------
  // run control, cycle counter
  // ------------------------------
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      running  <= 1'b0;
      halted   <= 1'b0;
      cycleCnt <= '0;
    end else if (start) begin
      running  <= 1'b1;
      halted   <= 1'b0;
      cycleCnt <= '0;                  // fresh count per run
    end else if (running) begin
      cycleCnt <= cycleCnt + 32'd1;
      if (wb.halt) begin               // halt retired
        running <= 1'b0;
        halted  <= 1'b1;
      end
    end
  end

  // access phase only ever follows a setup phase
  aEnableAfterSel: assert property (@(posedge clk) disable iff (!rstN)
    $rose(apbReq.enable) |-> $past(apbReq.sel));

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`default_nettype none

module regFile (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::regIdxT rs,
  input  cpuPkg::regIdxT rt,
  input  cpuPkg::wbT     wb,
  output cpuPkg::wordT   rsData,
  output cpuPkg::wordT   rtData
);
  import cpuPkg::*;

  wordT regs [32];

  // r0 reads zero, a write in this cycle wins over the stored value
  function automatic wordT readPort(regIdxT idx, wordT stored, wbT w);
    if (idx == '0)
      return '0;
    if (w.regWrite && w.rd == idx)
      return w.data;
    return stored;
  endfunction

  assign rsData = readPort(rs, regs[rs], wb);
  assign rtData = readPort(rt, regs[rt], wb);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wb.regWrite && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;         // r0 never written
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  // ------------------------------
  // widths with a meaning
  // ------------------------------
  typedef logic [31:0] wordT;    // data word, also byte address
  typedef logic [4:0]  regIdxT;  // register number
  typedef logic [7:0]  memIdxT;  // word offset inside a 1 KB apb window

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    rType = 6'h00,
    j     = 6'h02,
    beq   = 6'h04,
    bne   = 6'h05,
    addi  = 6'h08,
    lw    = 6'h23,
    sw    = 6'h2b,
    halt  = 6'h3f   // stops the core once it reaches writeback
  } opcodeT;

  // r-type funct field, instr[5:0]
  localparam logic [5:0] functAdd = 6'h20;
  localparam logic [5:0] functSub = 6'h22;
  localparam logic [5:0] functAnd = 6'h24;
  localparam logic [5:0] functOr  = 6'h25;
  localparam logic [5:0] functSlt = 6'h2a;

  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

  typedef enum logic [1:0] {
    fwdNone,  // value read in decode
    fwdMem,   // ex/mem result
    fwdWb     // writeback value
  } fwdSelT;

  // ------------------------------
  // pipeline registers
  // ------------------------------
  typedef struct packed {
    logic valid;
    wordT instr;
    wordT pcPlus4;
  } ifIdT;  // 65 bits

  typedef struct packed {
    logic   valid;
    wordT   rsVal;
    wordT   rtVal;
    wordT   imm;      // sign extended
    regIdxT rs;
    regIdxT rt;
    regIdxT rd;       // destination, rt or rd field
    aluOpT  aluOp;
    logic   aluSrc;   // b operand is imm
    logic   memRead;
    logic   memWrite;
    logic   regWrite;
    logic   halt;
  } idExT;

  typedef struct packed {
    logic   valid;
    wordT   result;     // alu result, byte address for lw/sw
    wordT   storeData;
    regIdxT rd;
    logic   memRead;
    logic   memWrite;
    logic   regWrite;
    logic   halt;
  } exMemT;

  typedef struct packed {
    logic   regWrite;
    regIdxT rd;
    wordT   data;
    logic   halt;
  } wbT;  // 39 bits, writeback bus and forwarding source

  // ------------------------------
  // apb slave
  // ------------------------------
  typedef struct packed {
    logic        sel;
    logic        enable;
    logic        write;
    logic [11:0] addr;
    wordT        wdata;
  } apbReqT;

  typedef struct packed {
    wordT rdata;
    logic ready;
    logic slvErr;
  } apbRspT;  // 34 bits

  // address map
  localparam logic [11:0] imemBase  = 12'h000;
  localparam logic [11:0] dmemBase  = 12'h400;
  localparam logic [11:0] ctrlAddr  = 12'h800;  // bit0 running, bit1 halted
  localparam logic [11:0] cycleAddr = 12'h804;

endpackage

`default_nettype wire
